// File: sources.f
+incdir+hdl
hdl/spm_pkg.sv
hdl/fifo_v3.sv
hdl/spm_bank.sv
hdl/spm_issue.sv
hdl/spm_queued_top.sv
bench/spm_checker.sv
bench/spm_monitor.sv
bench/spm_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = spm_tb
FILELIST  = sources.f
RUN_FLAGS = +verilator+error+limit+1000
LOG       = sim.log

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test failures found" $(LOG); then exit 1; fi
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: simulate clean

// File: bench/spm_tb.sv
// testbench for the queued scratchpad: clock, reset, stimulus table, watchdog, report
`default_nettype none

`include "spm_params.svh"

module spm_tb import spm_pkg::*; ();

    localparam int OP_WR    = 0;
    localparam int OP_RD    = 1;
    // read that stalls for credit and is dropped by the flush
    localparam int OP_STALL = 2;
    localparam int OP_FLUSH = 3;
    // wait until every accepted request has been answered
    localparam int OP_WAIT  = 4;
    // request queue must be full
    localparam int OP_FULL  = 5;

    // rsp_ready_i modes
    localparam int RDY_LOW  = 0;
    localparam int RDY_HIGH = 1;
    localparam int RDY_RAND = 2;

    logic      clk_i = 1'b0;
    logic      rst_ni;
    logic      flush_i;
    logic      req_valid_i;
    logic      req_we_i;
    spm_addr_t req_addr_i;
    spm_word_t req_wdata_i;
    logic      req_ready_o;
    logic      rsp_valid_o;
    spm_word_t rsp_rdata_o;
    logic      rsp_ready_i;

    string     cur_name;
    spm_word_t cur_exp;
    logic      chk_full;
    int        rdy_mode;
    int        mon_errs;
    int        mon_pending;
    int        total_errs;

    // stimulus table columns
    string     row_name[$];
    int        row_op[$];
    spm_addr_t row_addr[$];
    spm_word_t row_wdata[$];
    spm_word_t row_exp[$];
    int        row_mode[$];

    spm_queued_top dut0 (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_rdata_o (rsp_rdata_o),
        .rsp_ready_i (rsp_ready_i)
    );

    spm_monitor u_mon (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .req_valid_i (req_valid_i),
        .req_we_i    (req_we_i),
        .req_addr_i  (req_addr_i),
        .req_wdata_i (req_wdata_i),
        .req_ready_i (req_ready_o),
        .rsp_valid_i (rsp_valid_o),
        .rsp_rdata_i (rsp_rdata_o),
        .rsp_ready_i (rsp_ready_i),
        .name_i      (cur_name),
        .exp_i       (cur_exp),
        .chk_full_i  (chk_full),
        .err_cnt_o   (mon_errs),
        .pending_o   (mon_pending)
    );

    always #10 clk_i = !clk_i;

    // consumer side, changes on the falling edge
    // a new mode takes effect from the next falling edge on
    always @(negedge clk_i) begin
        case (rdy_mode)
            RDY_LOW:  rsp_ready_i = 1'b0;
            RDY_HIGH: rsp_ready_i = 1'b1;
            default:  rsp_ready_i = 1'($urandom % 2);
        endcase
    end

    task automatic add_row(input string name, input int op, input spm_addr_t addr,
                           input spm_word_t wdata, input spm_word_t exp, input int mode);
        row_name.push_back(name);
        row_op.push_back(op);
        row_addr.push_back(addr);
        row_wdata.push_back(wdata);
        row_exp.push_back(exp);
        row_mode.push_back(mode);
    endtask

    task automatic build_table();
        // expected values follow the writes earlier in the table, unwritten words are zero
        add_row("rst_rd_5", OP_RD, 6'd5, '0, 32'h0, RDY_HIGH);
        add_row("rst_rd_63", OP_RD, 6'd63, '0, 32'h0, RDY_HIGH);
        add_row("wr_1", OP_WR, 6'd1, 32'h1111_1111, '0, RDY_HIGH);
        add_row("wr_2", OP_WR, 6'd2, 32'h2222_2222, '0, RDY_HIGH);
        add_row("wr_3", OP_WR, 6'd3, 32'h3333_3333, '0, RDY_HIGH);
        add_row("rd_1", OP_RD, 6'd1, '0, 32'h1111_1111, RDY_HIGH);
        add_row("rd_2", OP_RD, 6'd2, '0, 32'h2222_2222, RDY_HIGH);
        add_row("rd_3", OP_RD, 6'd3, '0, 32'h3333_3333, RDY_HIGH);
        add_row("drain_a", OP_WAIT, '0, '0, '0, RDY_HIGH);
        // single read on idle queues, latency checked by the monitor
        add_row("lat_rd_2", OP_RD, 6'd2, '0, 32'h2222_2222, RDY_HIGH);
        add_row("drain_b", OP_WAIT, '0, '0, '0, RDY_HIGH);
        add_row("rnd_wr_10", OP_WR, 6'd10, 32'ha5a5_a5a5, '0, RDY_RAND);
        add_row("rnd_wr_11", OP_WR, 6'd11, 32'h5a5a_5a5a, '0, RDY_RAND);
        add_row("rnd_rd_10", OP_RD, 6'd10, '0, 32'ha5a5_a5a5, RDY_RAND);
        add_row("rnd_rd_11", OP_RD, 6'd11, '0, 32'h5a5a_5a5a, RDY_RAND);
        add_row("rnd_rd_1", OP_RD, 6'd1, '0, 32'h1111_1111, RDY_RAND);
        add_row("rnd_rd_3", OP_RD, 6'd3, '0, 32'h3333_3333, RDY_RAND);
        add_row("drain_c", OP_WAIT, '0, '0, '0, RDY_RAND);
        // fill both queues with the consumer stalled
        for (int i = 0; i < `SPM_RSP_DEPTH + `SPM_REQ_DEPTH; i++) begin
            add_row($sformatf("bp_rd_%0d", i), OP_RD, (i % 2) ? 6'd10 : 6'd1, '0,
                    (i % 2) ? 32'ha5a5_a5a5 : 32'h1111_1111, RDY_LOW);
        end
        add_row("bp_full", OP_FULL, '0, '0, '0, RDY_LOW);
        add_row("bp_rd_last", OP_RD, 6'd11, '0, 32'h5a5a_5a5a, RDY_HIGH);
        add_row("drain_d", OP_WAIT, '0, '0, '0, RDY_HIGH);
        // flush with a stalled read and writes queued behind it
        for (int i = 0; i < `SPM_RSP_DEPTH; i++) begin
            add_row($sformatf("fl_rd_%0d", i), OP_RD, 6'd3, '0, 32'h3333_3333, RDY_LOW);
        end
        add_row("fl_stall", OP_STALL, 6'd2, '0, 32'h2222_2222, RDY_LOW);
        add_row("fl_wr_1", OP_WR, 6'd1, 32'hdead_beef, '0, RDY_LOW);
        add_row("fl_wr_2", OP_WR, 6'd2, 32'hcafe_f00d, '0, RDY_LOW);
        add_row("fl_flush", OP_FLUSH, '0, '0, '0, RDY_LOW);
        add_row("fl_rd_old_1", OP_RD, 6'd1, '0, 32'h1111_1111, RDY_HIGH);
        add_row("fl_rd_old_2", OP_RD, 6'd2, '0, 32'h2222_2222, RDY_HIGH);
        add_row("drain_e", OP_WAIT, '0, '0, '0, RDY_HIGH);
    endtask

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic send_req(input logic we, input spm_addr_t addr, input spm_word_t wdata);
        logic accepted;
        req_valid_i = 1'b1;
        req_we_i    = we;
        req_addr_i  = addr;
        req_wdata_i = wdata;
        do begin
            @(posedge clk_i);
            accepted = req_ready_o;
        end while (!accepted);
        @(negedge clk_i);
        req_valid_i = 1'b0;
    endtask

    task automatic apply_row(input int i);
        rdy_mode <= row_mode[i];
        cur_name = row_name[i];
        cur_exp  = row_exp[i];
        case (row_op[i])
            OP_WR:             send_req(1'b1, row_addr[i], row_wdata[i]);
            OP_RD, OP_STALL:   send_req(1'b0, row_addr[i], '0);
            OP_FLUSH: begin
                flush_i = 1'b1;
                @(negedge clk_i);
                flush_i = 1'b0;
            end
            OP_FULL: begin
                chk_full = 1'b1;
                @(negedge clk_i);
                chk_full = 1'b0;
            end
            default: begin
                do @(posedge clk_i); while (mon_pending != 0);
                @(negedge clk_i);
            end
        endcase
    endtask

    // bounded by the table length
    initial begin
        #1;
        repeat (row_name.size() * 40) @(posedge clk_i);
        $display("timeout: the tests did not finish in the expected number of cycles");
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(39448));
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        req_valid_i = 1'b0;
        req_we_i    = 1'b0;
        req_addr_i  = '0;
        req_wdata_i = '0;
        rsp_ready_i = 1'b0;
        chk_full    = 1'b0;
        rdy_mode    = RDY_HIGH;
        cur_name    = "none";
        cur_exp     = '0;
        build_table();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rst_ni = 1'b1;
        for (int i = 0; i < row_name.size(); i++) begin
            apply_row(i);
        end
        repeat (2) @(negedge clk_i);
        total_errs = mon_errs + int'(dut0.u_chk.fail_cnt);
        $display("errors: monitor %0d, assertions %0d", mon_errs, dut0.u_chk.fail_cnt);
        if (total_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/spm_monitor.sv
// reference model of the queued scratchpad, predicts and checks every response
`default_nettype none

`include "spm_params.svh"

module spm_monitor import spm_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,
    input  wire logic      flush_i,
    input  wire logic      req_valid_i,
    input  wire logic      req_we_i,
    input  wire spm_addr_t req_addr_i,
    input  wire spm_word_t req_wdata_i,
    input  wire logic      req_ready_i,
    input  wire logic      rsp_valid_i,
    input  wire spm_word_t rsp_rdata_i,
    input  wire logic      rsp_ready_i,
    // row name and table value of the request on the bus
    input  string          name_i,
    input  wire spm_word_t exp_i,
    // request queue is expected to be full now
    input  wire logic      chk_full_i,
    output int             err_cnt_o,
    output int             pending_o
);

    spm_word_t   model_mem [2 ** `SPM_ADDR_W];
    // accepted but not issued, in request order
    spm_req_t    pend_q[$];
    string       pend_name_q[$];
    spm_word_t   pend_tab_q[$];
    // issued reads not consumed yet
    spm_word_t   exp_q[$];
    spm_word_t   tab_q[$];
    string       name_q[$];
    int unsigned credits;
    int          lat;
    logic        after_rst;

    always @(posedge clk_i or negedge rst_ni) begin
        spm_word_t   e;
        spm_word_t   t;
        string       n;
        int unsigned used;
        logic        was_idle;
        spm_req_t    h;
        if (!rst_ni) begin
            foreach (model_mem[i]) model_mem[i] = '0;
            pend_q.delete();
            pend_name_q.delete();
            pend_tab_q.delete();
            exp_q.delete();
            tab_q.delete();
            name_q.delete();
            credits   = 0;
            lat       = 0;
            after_rst = 1'b1;
            err_cnt_o = 0;
            pending_o <= 0;
        end else begin
            if (after_rst && (!req_ready_i || rsp_valid_i)) begin
                $display("after reset the request side is not ready or a response is valid");
                err_cnt_o++;
            end
            after_rst = 1'b0;
            if (chk_full_i && req_ready_i) begin
                $display("request queue still accepts although it should be full");
                err_cnt_o++;
            end
            if (flush_i) begin
                // queued requests and every outstanding read are dropped
                pend_q.delete();
                pend_name_q.delete();
                pend_tab_q.delete();
                exp_q.delete();
                tab_q.delete();
                name_q.delete();
                credits = 0;
                lat     = 0;
            end else begin
                was_idle = (pend_q.size() == 0) && (credits == 0);
                // idle read, valid must rise exactly one edge after acceptance
                if (lat == 2 && rsp_valid_i) begin
                    $display("response valid too early for an idle read");
                    err_cnt_o++;
                end
                if (lat == 1 && !rsp_valid_i) begin
                    $display("idle read did not answer one cycle after acceptance");
                    err_cnt_o++;
                end
                if (lat > 0) lat = lat - 1;
                if (req_valid_i && req_ready_i) begin
                    h.we    = req_we_i;
                    h.addr  = req_addr_i;
                    h.wdata = req_wdata_i;
                    pend_q.push_back(h);
                    pend_name_q.push_back(name_i);
                    pend_tab_q.push_back(exp_i);
                    if (!req_we_i && was_idle) lat = 2;
                end
                // credit check sees the count before this cycle's pop
                used = credits;
                if (rsp_valid_i && exp_q.size() == 0) begin
                    $display("response valid while no read is outstanding");
                    err_cnt_o++;
                end else if (rsp_valid_i && rsp_ready_i) begin
                    e = exp_q.pop_front();
                    t = tab_q.pop_front();
                    n = name_q.pop_front();
                    if (rsp_rdata_i !== e) begin
                        $display("MISMATCH %s expected %h actual %h", n, e, rsp_rdata_i);
                        err_cnt_o++;
                    end
                    if (t !== e) begin
                        $display("table value for %s is %h but the model predicts %h", n, t, e);
                        err_cnt_o++;
                    end
                    credits = credits - 1;
                end
                if (pend_q.size() > 0 && (pend_q[0].we || used < `SPM_RSP_DEPTH)) begin
                    h = pend_q.pop_front();
                    n = pend_name_q.pop_front();
                    t = pend_tab_q.pop_front();
                    if (h.we) begin
                        model_mem[h.addr] = h.wdata;
                    end else begin
                        exp_q.push_back(model_mem[h.addr]);
                        tab_q.push_back(t);
                        name_q.push_back(n);
                        credits = credits + 1;
                    end
                end
            end
            pending_o <= pend_q.size() + exp_q.size();
        end
    end

endmodule

`default_nettype wire

// File: bench/spm_checker.sv
// concurrent assertions on the scratchpad top, attached by bind
`default_nettype none

`include "spm_params.svh"

module spm_checker (
    input  wire logic                                clk_i,
    input  wire logic                                rst_ni,
    input  wire logic                                flush_i,
    input  wire logic                                rsp_valid_i,
    input  wire logic                                rsp_ready_i,
    input  wire logic [`SPM_DATA_W-1:0]              rsp_rdata_i,
    input  wire logic [$clog2(`SPM_RSP_DEPTH+1)-1:0] inflight_i,
    input  wire logic                                rsp_push_i,
    input  wire logic                                rsp_full_i
);

    // number of assertion failures
    int unsigned fail_cnt = 0;

    // held response keeps its data
    a_rsp_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        rsp_valid_i && !rsp_ready_i && !flush_i |=> $stable(rsp_rdata_i))
        else begin
            $error("response data changed while the response was held");
            fail_cnt++;
        end

    // credits never exceed the response queue depth
    a_inflight_max: assert property (@(posedge clk_i) disable iff (!rst_ni)
        inflight_i <= `SPM_RSP_DEPTH)
        else begin
            $error("reads in flight exceed the response queue depth");
            fail_cnt++;
        end

    // bank data never arrives at a full response queue
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(rsp_push_i && rsp_full_i))
        else begin
            $error("read data pushed into a full response queue");
            fail_cnt++;
        end

    a_flush_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !rsp_valid_i)
        else begin
            $error("response still valid after a flush");
            fail_cnt++;
        end

    // response queue empty in the cycle after reset
    a_reset_empty: assert property (@(posedge clk_i) !rst_ni |=> !rsp_valid_i)
        else begin
            $error("response valid right after reset");
            fail_cnt++;
        end

endmodule

bind spm_queued_top spm_checker u_chk (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .flush_i     (flush_i),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i),
    .rsp_rdata_i (rsp_rdata_o),
    .inflight_i  (u_issue.inflight_q),
    .rsp_push_i  (rd_valid),
    .rsp_full_i  (rsp_full)
);

`default_nettype wire

// File: hdl/spm_queued_top.sv
// queued scratchpad top: request queue, issue stage, bank, response queue
`default_nettype none

`include "spm_params.svh"

module spm_queued_top import spm_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,
    input  wire logic      flush_i,
    // request side
    input  wire logic      req_valid_i,
    input  wire logic      req_we_i,
    input  wire spm_addr_t req_addr_i,
    input  wire spm_word_t req_wdata_i,
    output logic           req_ready_o,
    // response side
    output logic           rsp_valid_o,
    output spm_word_t      rsp_rdata_o,
    input  wire logic      rsp_ready_i
);

    localparam int unsigned RspUsageW = $clog2(`SPM_RSP_DEPTH);

    spm_req_t              req_in;
    spm_req_t              req_head;
    logic                  req_full;
    logic                  req_empty;
    logic                  req_pop;

    logic                  bank_en;
    logic                  bank_we;
    spm_addr_t             bank_addr;
    spm_word_t             bank_wdata;
    logic                  rd_valid;
    spm_word_t             rd_data;

    logic                  rsp_full;
    logic                  rsp_empty;
    logic [RspUsageW-1:0]  rsp_usage;

    assign req_in.we    = req_we_i;
    assign req_in.addr  = req_addr_i;
    assign req_in.wdata = req_wdata_i;

    assign req_ready_o = !req_full;
    assign rsp_valid_o = !rsp_empty;

    // fall-through, so an idle read reaches the bank on its accept cycle
    fifo_v3 #(
        .FALL_THROUGH (1'b1),
        .DATA_WIDTH   ($bits(spm_req_t)),
        .DEPTH        (`SPM_REQ_DEPTH),
        .dtype        (spm_req_t)
    ) u_req_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .full_o  (req_full),
        .empty_o (req_empty),
        .usage_o (),
        .data_i  (req_in),
        .push_i  (req_valid_i && req_ready_o),
        .data_o  (req_head),
        .pop_i   (req_pop)
    );

    spm_issue u_issue (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .head_i       (req_head),
        .req_empty_i  (req_empty),
        .req_pop_o    (req_pop),
        .bank_en_o    (bank_en),
        .bank_we_o    (bank_we),
        .bank_addr_o  (bank_addr),
        .bank_wdata_o (bank_wdata),
        .rsp_usage_i  (rsp_usage),
        .rsp_full_i   (rsp_full),
        .rd_valid_i   (rd_valid)
    );

    spm_bank u_bank (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .en_i       (bank_en),
        .we_i       (bank_we),
        .addr_i     (bank_addr),
        .wdata_i    (bank_wdata),
        .rd_valid_o (rd_valid),
        .rd_data_o  (rd_data)
    );

    // registered, the issue credits guarantee room for every rd_valid
    fifo_v3 #(
        .FALL_THROUGH (1'b0),
        .DATA_WIDTH   (`SPM_DATA_W),
        .DEPTH        (`SPM_RSP_DEPTH),
        .dtype        (spm_word_t)
    ) u_rsp_fifo (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .full_o  (rsp_full),
        .empty_o (rsp_empty),
        .usage_o (rsp_usage),
        .data_i  (rd_data),
        .push_i  (rd_valid),
        .data_o  (rsp_rdata_o),
        .pop_i   (rsp_ready_i && rsp_valid_o)
    );

endmodule

`default_nettype wire

// File: hdl/spm_issue.sv
// in-order issue stage with read credits against the response queue
`default_nettype none

`include "spm_params.svh"

module spm_issue import spm_pkg::*; (
    input  wire logic                               clk_i,
    input  wire logic                               rst_ni,
    input  wire logic                               flush_i,
    // request queue head
    input  wire spm_req_t                           head_i,
    input  wire logic                               req_empty_i,
    output logic                                    req_pop_o,
    // bank access
    output logic                                    bank_en_o,
    output logic                                    bank_we_o,
    output spm_addr_t                               bank_addr_o,
    output spm_word_t                               bank_wdata_o,
    // response queue state and returning reads
    input  wire logic [$clog2(`SPM_RSP_DEPTH)-1:0] rsp_usage_i,
    input  wire logic                               rsp_full_i,
    input  wire logic                               rd_valid_i
);

    localparam int unsigned CntW = $clog2(`SPM_RSP_DEPTH + 1);

    // reads sent to the bank whose data has not reached the queue yet
    logic [CntW-1:0] inflight_q;
    // stored responses, usage wraps to zero when full
    logic [CntW-1:0] rsp_occ;
    logic            credit_ok;
    logic            issue;
    logic            issue_rd;

    assign rsp_occ = rsp_full_i ? CntW'(`SPM_RSP_DEPTH) : CntW'(rsp_usage_i);

    // room must exist for every read already on its way plus this one
    assign credit_ok = ({1'b0, rsp_occ} + {1'b0, inflight_q}) < (CntW + 1)'(`SPM_RSP_DEPTH);

    // writes go whenever there is a head
    // a read without credit holds everything behind it
    // nothing issues during flush, so no read returns after it
    assign issue    = !req_empty_i && !flush_i && (head_i.we || credit_ok);
    assign issue_rd = issue && !head_i.we;

    // pop and bank access happen in the same cycle
    assign req_pop_o    = issue;
    assign bank_en_o    = issue;
    assign bank_we_o    = head_i.we;
    assign bank_addr_o  = head_i.addr;
    assign bank_wdata_o = head_i.wdata;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            inflight_q <= '0;
        end else if (flush_i) begin
            // a read returning in the flush cycle is dropped by the queue flush
            inflight_q <= '0;
        end else begin
            case ({issue_rd, rd_valid_i})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/spm_bank.sv
// register-based word storage with synchronous write and one-cycle read
`default_nettype none

`include "spm_params.svh"

module spm_bank import spm_pkg::*; (
    input  wire logic      clk_i,
    input  wire logic      rst_ni,
    // access from the issue stage
    input  wire logic      en_i,
    input  wire logic      we_i,
    input  wire spm_addr_t addr_i,
    input  wire spm_word_t wdata_i,
    // read answer, one cycle after a read enable
    output logic           rd_valid_o,
    output spm_word_t      rd_data_o
);

    localparam int unsigned NumWords = 2 ** `SPM_ADDR_W;

    spm_word_t mem_q [NumWords];

    // storage and read strobe, all words start at zero
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int i = 0; i < NumWords; i++) begin
                mem_q[i] <= '0;
            end
            rd_valid_o <= 1'b0;
        end else begin
            if (en_i && we_i) begin
                mem_q[addr_i] <= wdata_i;
            end
            rd_valid_o <= en_i && !we_i;
        end
    end

    // read data register, loaded on a read enable
    always_ff @(posedge clk_i) begin
        if (en_i && !we_i) begin
            rd_data_o <= mem_q[addr_i];
        end
    end

endmodule

`default_nettype wire

// File: hdl/fifo_v3.sv
// generic circular-buffer FIFO with a payload type parameter and fall-through option
`default_nettype none

module fifo_v3 #(
    // empty queue hands data_i straight to data_o
    parameter bit          FALL_THROUGH = 1'b0,
    // width used only when dtype keeps its default
    parameter int unsigned DATA_WIDTH   = 32,
    // number of entries, at least one
    parameter int unsigned DEPTH        = 8,
    parameter type         dtype        = logic [DATA_WIDTH-1:0],
    // derived from DEPTH, leave at default
    parameter int unsigned ADDR_DEPTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1
) (
    input  wire logic                  clk_i,
    input  wire logic                  rst_ni,
    // synchronous clear of pointers and count
    input  wire logic                  flush_i,
    // status
    output logic                       full_o,
    output logic                       empty_o,
    output logic      [ADDR_DEPTH-1:0] usage_o,
    // write side
    input  wire dtype                  data_i,
    input  wire logic                  push_i,
    // read side
    output dtype                       data_o,
    input  wire logic                  pop_i
);

    logic [ADDR_DEPTH-1:0] rd_ptr_q, rd_ptr_n;
    logic [ADDR_DEPTH-1:0] wr_ptr_q, wr_ptr_n;
    // one bit wider than the pointers so a full queue is distinct from empty
    logic [ADDR_DEPTH:0]   cnt_q, cnt_n;
    logic                  push_ok;
    logic                  pop_ok;
    logic                  bypass;

    // storage, written on push only
    dtype mem_q [DEPTH];

    // usage wraps to zero when full, full_o tells the two apart
    assign usage_o = cnt_q[ADDR_DEPTH-1:0];
    assign full_o  = (cnt_q == DEPTH[ADDR_DEPTH:0]);

    // in fall-through mode a push into an empty queue is visible at once
    assign bypass  = FALL_THROUGH && (cnt_q == '0) && push_i;
    assign empty_o = (cnt_q == '0) && !bypass;

    assign push_ok = push_i && !full_o;
    assign pop_ok  = pop_i && !empty_o;

    assign data_o = bypass ? data_i : mem_q[rd_ptr_q];

    always_comb begin
        rd_ptr_n = rd_ptr_q;
        wr_ptr_n = wr_ptr_q;
        cnt_n    = cnt_q;

        if (push_ok) begin
            // wrap explicitly, matters for depths that are not a power of two
            if (wr_ptr_q == ADDR_DEPTH'(DEPTH - 1)) begin
                wr_ptr_n = '0;
            end else begin
                wr_ptr_n = wr_ptr_q + 1'b1;
            end
            cnt_n = cnt_n + 1'b1;
        end

        if (pop_ok) begin
            if (rd_ptr_q == ADDR_DEPTH'(DEPTH - 1)) begin
                rd_ptr_n = '0;
            end else begin
                rd_ptr_n = rd_ptr_q + 1'b1;
            end
            cnt_n = cnt_n - 1'b1;
        end

        // word pushed and popped in the same cycle through the bypass
        // never lands in storage, so nothing moves
        if (bypass && pop_i) begin
            rd_ptr_n = rd_ptr_q;
            wr_ptr_n = wr_ptr_q;
            cnt_n    = cnt_q;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else if (flush_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            rd_ptr_q <= rd_ptr_n;
            wr_ptr_q <= wr_ptr_n;
            cnt_q    <= cnt_n;
        end
    end

    // payload slots, loaded at the write pointer
    always_ff @(posedge clk_i) begin
        if (push_ok) begin
            mem_q[wr_ptr_q] <= data_i;
        end
    end

endmodule

`default_nettype wire

// File: hdl/spm_pkg.sv
// types shared by the scratchpad RTL and its testbench
`default_nettype none

`include "spm_params.svh"

package spm_pkg;

    // one storage word, also the response payload
    typedef logic [`SPM_DATA_W-1:0] spm_word_t;

    // word address into the bank
    typedef logic [`SPM_ADDR_W-1:0] spm_addr_t;

    // request queue payload
    // wdata is ignored for reads
    typedef struct packed {
        logic      we;
        spm_addr_t addr;
        spm_word_t wdata;
    } spm_req_t;

endpackage

`default_nettype wire

// File: hdl/spm_params.svh
// width and depth macros for the queued scratchpad memory
`ifndef SPM_PARAMS_SVH
`define SPM_PARAMS_SVH

// word address bits, 64 words of storage
`define SPM_ADDR_W 6

// width of one data word
`define SPM_DATA_W 32

// request queue entries
`define SPM_REQ_DEPTH 4

// response queue entries
// also the limit on reads outstanding at once
`define SPM_RSP_DEPTH 4

`endif
